/* verilog/wb_config.svh */
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// data path and pc width
`define WB_XLEN 32

// register index width
`define WB_REGW 5

// one quotient bit per iteration
`define WB_DIV_CYCLES 32

// vppn taken from the low bits of badv
`define WB_VPPN_W 19

`endif

/* verilog/wb_pkg.sv */
`default_nettype none

`include "wb_config.svh"

package wb_pkg;

    typedef enum logic [2:0] {
        WB_NOP   = 3'd0,
        WB_ALU   = 3'd1,
        WB_CSR   = 3'd2,
        WB_DIV   = 3'd3,
        WB_LOAD  = 3'd4,
        WB_STORE = 3'd5
    } wb_kind_e;

    // rem_sel picks remainder over quotient
    typedef struct packed {
        logic [1:0] rsvd;
        logic       is_signed;
        logic       rem_sel;
    } div_cond_t;

    typedef struct packed {
        logic       rsvd;
        logic       store;
        logic [1:0] size;
    } mem_cond_t;

    // one cond field, read per kind
    typedef union packed {
        div_cond_t div;
        mem_cond_t mem;
    } wb_cond_u;

    typedef enum logic [6:0] {
        ECODE_PIL  = 7'h01,
        ECODE_PIS  = 7'h02,
        ECODE_PIF  = 7'h03,
        ECODE_PME  = 7'h04,
        ECODE_PPI  = 7'h07,
        ECODE_ADEF = 7'h08,
        ECODE_ALE  = 7'h09,
        ECODE_SYS  = 7'h0b,
        ECODE_BRK  = 7'h0c,
        ECODE_TLBR = 7'h3f
    } wb_ecode_e;

    typedef struct packed {
        logic                flag;
        wb_ecode_e           ecode;
        logic [`WB_XLEN-1:0] badv;
    } wb_exc_t;

    typedef struct packed {
        wb_kind_e kind;
        wb_cond_u cond;
        wb_exc_t  exc;
    } wb_uop_t;

    // op_a is the alu result or the dividend, op_b the divisor
    typedef struct packed {
        logic                valid;
        logic [`WB_XLEN-1:0] pc;
        logic [`WB_XLEN-1:0] inst;
        wb_uop_t             uop;
        logic [`WB_REGW-1:0] rd;
        logic [`WB_XLEN-1:0] op_a;
        logic [`WB_XLEN-1:0] op_b;
    } wb_slot_t;

    typedef enum logic [2:0] {
        SRC_NONE = 3'd0,
        SRC_ALU  = 3'd1,
        SRC_LINK = 3'd2,
        SRC_CSR  = 3'd3,
        SRC_DIV  = 3'd4
    } wb_src_e;

    typedef struct packed {
        logic                we;
        logic [`WB_REGW-1:0] rd;
        logic [`WB_XLEN-1:0] data;
    } wb_port_t;

    typedef struct packed {
        logic                valid;
        logic [`WB_REGW-1:0] rd;
        logic [`WB_XLEN-1:0] data;
    } ld_resp_t;

    typedef struct packed {
        logic                  flush;
        logic                  wen_era;
        logic [`WB_XLEN-1:0]   era;
        logic                  wen_badv;
        logic [`WB_XLEN-1:0]   badv;
        logic                  wen_vppn;
        logic [`WB_VPPN_W-1:0] vppn;
        logic                  tlb_refill;
        wb_ecode_e             ecode;
    } exc_csr_t;

endpackage

`default_nettype wire

/* verilog/uop_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module uop_decode (
    input  wb_pkg::wb_slot_t slot0,
    input  wb_pkg::wb_slot_t slot1,
    output wb_pkg::wb_src_e  src0,
    output wb_pkg::wb_src_e  src1
);

    // jirl major opcode, inst[30:26]
    localparam logic [4:0] OP_JIRL = 5'b10011;

    wb_pkg::wb_src_e raw1;

    function automatic wb_pkg::wb_src_e classify(input wb_pkg::wb_slot_t s);
        wb_pkg::wb_src_e src;
        src = wb_pkg::SRC_NONE;
        if (s.valid) begin
            case (s.uop.kind)
                wb_pkg::WB_ALU: begin
                    if (s.inst[30:26] == OP_JIRL) begin
                        src = wb_pkg::SRC_LINK;
                    end else begin
                        src = wb_pkg::SRC_ALU;
                    end
                end
                wb_pkg::WB_CSR: src = wb_pkg::SRC_CSR;
                wb_pkg::WB_DIV: src = wb_pkg::SRC_DIV;
                // loads return on port 2, stores write nothing
                default:        src = wb_pkg::SRC_NONE;
            endcase
        end
        return src;
    endfunction

    assign src0 = classify(slot0);
    assign raw1 = classify(slot1);

    // csr only from slot 0, one divider per pair
    always_comb begin
        if (raw1 == wb_pkg::SRC_CSR) begin
            src1 = wb_pkg::SRC_NONE;
        end else if (raw1 == wb_pkg::SRC_DIV && src0 == wb_pkg::SRC_DIV) begin
            src1 = wb_pkg::SRC_NONE;
        end else begin
            src1 = raw1;
        end
    end

    always_comb begin
        a_csr_slot0: assert (!(slot1.valid && slot1.uop.kind == wb_pkg::WB_CSR))
            else $error("uop_decode: csr issued in slot 1");
        a_one_div: assert (!(slot0.valid && slot1.valid &&
                             slot0.uop.kind == wb_pkg::WB_DIV &&
                             slot1.uop.kind == wb_pkg::WB_DIV))
            else $error("uop_decode: two divides in one pair");
    end

endmodule

`default_nettype wire

/* verilog/div_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "wb_config.svh"

module div_unit (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                start,
    input  logic [`WB_XLEN-1:0] dividend,
    input  logic [`WB_XLEN-1:0] divisor,
    output logic                busy,
    output logic                done,
    output logic [`WB_XLEN-1:0] quotient,
    output logic [`WB_XLEN-1:0] remainder
);

    localparam int XLEN  = `WB_XLEN;
    localparam int CNT_W = $clog2(`WB_DIV_CYCLES);

    logic [CNT_W-1:0] cnt;
    logic             last;
    logic [XLEN-1:0]  dsor_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN:0]    trial;
    logic [XLEN+1:0]  diff;
    logic             fits;

    // shift next dividend bit into the partial remainder
    assign trial = {rem_q, quo_q[XLEN-1]};
    assign diff  = {1'b0, trial} - {2'b00, dsor_q};
    assign fits  = !diff[XLEN+1];
    assign last  = (cnt == CNT_W'(`WB_DIV_CYCLES - 1));

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= busy && last;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // divisor of zero never borrows, so quotient ends all ones
    // and the remainder ends as the dividend
    always_ff @(posedge clk) begin
        if (start) begin
            dsor_q <= divisor;
            quo_q  <= dividend;
            rem_q  <= '0;
        end else if (busy) begin
            if (fits) begin
                rem_q <= diff[XLEN-1:0];
            end else begin
                rem_q <= trial[XLEN-1:0];
            end
            quo_q <= {quo_q[XLEN-2:0], fits};
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

    a_no_restart: assert property (@(posedge clk) disable iff (!aresetn)
        start |-> !busy)
        else $error("div_unit: start while busy");

endmodule

`default_nettype wire

/* verilog/wb_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "wb_config.svh"

module wb_stage (
    input  logic                clk,
    input  logic                aresetn,
    input  wb_pkg::wb_slot_t    slot0,
    input  wb_pkg::wb_slot_t    slot1,
    input  wb_pkg::wb_src_e     src0,
    input  wb_pkg::wb_src_e     src1,
    input  logic                div_done,
    input  logic                div_busy,
    input  logic [`WB_XLEN-1:0] quotient,
    input  logic [`WB_XLEN-1:0] remainder,
    input  logic [`WB_XLEN-1:0] csr_rdata,
    input  logic                csr_ready,
    input  wb_pkg::ld_resp_t    ld_resp,
    input  logic                squash,
    output logic                div_start,
    output logic [`WB_XLEN-1:0] dividend,
    output logic [`WB_XLEN-1:0] divisor,
    output logic                allowin,
    output wb_pkg::wb_port_t    wport0,
    output wb_pkg::wb_port_t    wport1,
    output wb_pkg::wb_port_t    wport2
);

    logic csr_wait;
    logic go0;
    logic go1;
    logic div_sel1;

    // pending divide
    logic                div_pend;
    logic                div_port;
    logic [`WB_REGW-1:0] div_rd;
    logic                div_rem;

    wb_pkg::wb_port_t    port_d [3];
    logic                we_q   [3];
    logic [`WB_REGW-1:0] rd_q   [3];
    logic [`WB_XLEN-1:0] data_q [3];

    function automatic wb_pkg::wb_port_t slot_write(
        input wb_pkg::wb_slot_t    s,
        input wb_pkg::wb_src_e     src,
        input logic                go,
        input logic [`WB_XLEN-1:0] csr_data
    );
        wb_pkg::wb_port_t p;
        p.rd = s.rd;
        p.we = go && (src == wb_pkg::SRC_ALU || src == wb_pkg::SRC_LINK ||
                      src == wb_pkg::SRC_CSR);
        case (src)
            wb_pkg::SRC_LINK: p.data = s.op_a + 4;
            wb_pkg::SRC_CSR:  p.data = csr_data;
            default:          p.data = s.op_a;
        endcase
        return p;
    endfunction

    // pending csr holds the pair until its read data is back
    assign csr_wait = slot0.valid && src0 == wb_pkg::SRC_CSR && !csr_ready;
    assign allowin  = !div_busy && !csr_wait;

    assign go0 = slot0.valid && allowin && !squash;
    assign go1 = slot1.valid && allowin && !squash;

    assign div_sel1  = (src1 == wb_pkg::SRC_DIV);
    assign div_start = (go0 && src0 == wb_pkg::SRC_DIV) || (go1 && div_sel1);
    assign dividend  = div_sel1 ? slot1.op_a : slot0.op_a;
    assign divisor   = div_sel1 ? slot1.op_b : slot0.op_b;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            div_pend <= 1'b0;
        end else if (div_start) begin
            div_pend <= 1'b1;
        end else if (div_done) begin
            div_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_port <= div_sel1;
            div_rd   <= div_sel1 ? slot1.rd : slot0.rd;
            div_rem  <= div_sel1 ? slot1.uop.cond.div.rem_sel : slot0.uop.cond.div.rem_sel;
        end
    end

    always_comb begin
        port_d[0] = slot_write(slot0, src0, go0, csr_rdata);
        port_d[1] = slot_write(slot1, src1, go1, csr_rdata);
        port_d[2] = '{we: ld_resp.valid, rd: ld_resp.rd, data: ld_resp.data};
        // finished divide wins its port
        if (div_pend && div_done) begin
            port_d[div_port].we   = 1'b1;
            port_d[div_port].rd   = div_rd;
            port_d[div_port].data = div_rem ? remainder : quotient;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 3; i++) begin
                we_q[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                we_q[i] <= port_d[i].we;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (port_d[i].we) begin
                rd_q[i]   <= port_d[i].rd;
                data_q[i] <= port_d[i].data;
            end
        end
    end

    assign wport0 = '{we: we_q[0], rd: rd_q[0], data: data_q[0]};
    assign wport1 = '{we: we_q[1], rd: rd_q[1], data: data_q[1]};
    assign wport2 = '{we: we_q[2], rd: rd_q[2], data: data_q[2]};

    a_port_agree: assert property (@(posedge clk) disable iff (!aresetn)
        (wport0.we && wport1.we && wport0.rd == wport1.rd) |-> (wport0.data == wport1.data))
        else $error("wb_stage: ports 0 and 1 disagree on rd %0d", wport0.rd);

endmodule

`default_nettype wire

/* verilog/exc_commit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "wb_config.svh"

module exc_commit (
    input  logic                clk,
    input  logic                aresetn,
    input  wb_pkg::wb_slot_t    slot0,
    input  logic                accept,
    input  logic                irq,
    input  logic                csr_done,
    input  logic [`WB_XLEN-1:0] eentry,
    input  logic [`WB_XLEN-1:0] tlbrentry,
    output wb_pkg::exc_csr_t    exc,
    output logic                squash,
    output logic                redirect,
    output logic [`WB_XLEN-1:0] redirect_pc
);

    logic                exc_take;
    logic                set_badv;
    logic                set_vppn;
    logic                refill;
    logic [`WB_XLEN-1:0] era_src;
    logic [`WB_XLEN-1:0] last_pc;

    logic                flush_q;
    logic                badv_wen_q;
    logic                vppn_wen_q;
    logic                refill_q;
    logic [`WB_XLEN-1:0] era_q;
    logic [`WB_XLEN-1:0] badv_q;
    wb_pkg::wb_ecode_e   ecode_q;

    assign exc_take = accept && slot0.uop.exc.flag;
    assign squash   = exc_take || irq;
    assign refill   = (slot0.uop.exc.ecode == wb_pkg::ECODE_TLBR);
    // interrupt with nothing accepted returns to the last pair
    assign era_src  = accept ? slot0.pc : last_pc;

    // address faults record badv, tlb faults also vppn
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        case (slot0.uop.exc.ecode)
            wb_pkg::ECODE_PIL, wb_pkg::ECODE_PIS, wb_pkg::ECODE_PIF,
            wb_pkg::ECODE_PME, wb_pkg::ECODE_PPI, wb_pkg::ECODE_TLBR: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            wb_pkg::ECODE_ADEF, wb_pkg::ECODE_ALE: begin
                set_badv = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush_q    <= 1'b0;
            badv_wen_q <= 1'b0;
            vppn_wen_q <= 1'b0;
            refill_q   <= 1'b0;
            redirect   <= 1'b0;
            last_pc    <= '0;
            era_q      <= '0;
            badv_q     <= '0;
            ecode_q    <= wb_pkg::wb_ecode_e'(7'h00);
        end else begin
            flush_q    <= squash;
            badv_wen_q <= exc_take && set_badv;
            vppn_wen_q <= exc_take && set_vppn;
            refill_q   <= exc_take && refill;
            redirect   <= squash || csr_done;
            if (accept) begin
                last_pc <= slot0.pc;
            end
            if (squash) begin
                era_q  <= era_src;
                badv_q <= slot0.uop.exc.badv;
                // interrupt reports ecode 0
                ecode_q <= exc_take ? slot0.uop.exc.ecode : wb_pkg::wb_ecode_e'(7'h00);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (squash) begin
            redirect_pc <= (exc_take && refill) ? tlbrentry : eentry;
        end else if (csr_done) begin
            redirect_pc <= slot0.pc + 4;
        end
    end

    assign exc = '{
        flush:      flush_q,
        wen_era:    flush_q,
        era:        era_q,
        wen_badv:   badv_wen_q,
        badv:       badv_q,
        wen_vppn:   vppn_wen_q,
        vppn:       badv_q[`WB_VPPN_W-1:0],
        tlb_refill: refill_q,
        ecode:      ecode_q
    };

    a_redirect_src: assert property (@(posedge clk) disable iff (!aresetn)
        redirect |-> (flush_q || $past(csr_done)))
        else $error("exc_commit: redirect without flush or csr completion");

endmodule

`default_nettype wire

/* verilog/wb_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "wb_config.svh"

module wb_top (
    input  logic                clk,
    input  logic                aresetn,
    input  wb_pkg::wb_slot_t    slot0,
    input  wb_pkg::wb_slot_t    slot1,
    input  logic [`WB_XLEN-1:0] csr_rdata,
    input  logic                csr_ready,
    input  wb_pkg::ld_resp_t    ld_resp,
    input  logic                irq,
    input  logic [`WB_XLEN-1:0] eentry,
    input  logic [`WB_XLEN-1:0] tlbrentry,
    output logic                allowin,
    output wb_pkg::wb_port_t    wport0,
    output wb_pkg::wb_port_t    wport1,
    output wb_pkg::wb_port_t    wport2,
    output wb_pkg::exc_csr_t    exc,
    output logic                redirect,
    output logic [`WB_XLEN-1:0] redirect_pc
);

    wb_pkg::wb_src_e     src0;
    wb_pkg::wb_src_e     src1;
    logic                div_start;
    logic                div_busy;
    logic                div_done;
    logic [`WB_XLEN-1:0] dividend;
    logic [`WB_XLEN-1:0] divisor;
    logic [`WB_XLEN-1:0] quotient;
    logic [`WB_XLEN-1:0] remainder;
    logic                squash;
    logic                accept;
    logic                csr_done;

    assign accept   = slot0.valid && allowin;
    // csr accept only happens with csr_ready high
    assign csr_done = accept && src0 == wb_pkg::SRC_CSR;

    uop_decode u_decode (
        .slot0 (slot0),
        .slot1 (slot1),
        .src0  (src0),
        .src1  (src1)
    );

    div_unit u_div (
        .clk       (clk),
        .aresetn   (aresetn),
        .start     (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    wb_stage u_wb (
        .clk       (clk),
        .aresetn   (aresetn),
        .slot0     (slot0),
        .slot1     (slot1),
        .src0      (src0),
        .src1      (src1),
        .div_done  (div_done),
        .div_busy  (div_busy),
        .quotient  (quotient),
        .remainder (remainder),
        .csr_rdata (csr_rdata),
        .csr_ready (csr_ready),
        .ld_resp   (ld_resp),
        .squash    (squash),
        .div_start (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .allowin   (allowin),
        .wport0    (wport0),
        .wport1    (wport1),
        .wport2    (wport2)
    );

    exc_commit u_exc (
        .clk         (clk),
        .aresetn     (aresetn),
        .slot0       (slot0),
        .accept      (accept),
        .irq         (irq),
        .csr_done    (csr_done),
        .eentry      (eentry),
        .tlbrentry   (tlbrentry),
        .exc         (exc),
        .squash      (squash),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

/* verif/wb_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "wb_config.svh"

module wb_tb;

    localparam int N_ENTRIES   = 24;
    localparam int CYCLE_LIMIT = N_ENTRIES * (`WB_DIV_CYCLES + 8);
    localparam logic [31:0] EENTRY    = 32'h1c00_8000;
    localparam logic [31:0] TLBRENTRY = 32'h1c00_f000;

    typedef struct packed {
        wb_pkg::wb_slot_t s0;
        wb_pkg::wb_slot_t s1;
        logic [7:0]       csr_delay;
        logic [31:0]      csr_data;
        wb_pkg::ld_resp_t ld;
        logic             irq;
    } entry_t;

    logic clk = 1'b0;
    logic aresetn;
    wb_pkg::wb_slot_t slot0;
    wb_pkg::wb_slot_t slot1;
    logic [31:0]      csr_rdata;
    logic             csr_ready;
    wb_pkg::ld_resp_t ld_resp;
    logic             irq;
    logic             allowin;
    wb_pkg::wb_port_t wport0;
    wb_pkg::wb_port_t wport1;
    wb_pkg::wb_port_t wport2;
    wb_pkg::exc_csr_t exc;
    logic             redirect;
    logic [31:0]      redirect_pc;

    entry_t      table_q [N_ENTRIES];
    int          mismatches = 0;
    int          cycles = 0;
    logic [31:0] last_pc = '0;

    wb_top u_wb_top (
        .clk(clk), .aresetn(aresetn), .slot0(slot0), .slot1(slot1),
        .csr_rdata(csr_rdata), .csr_ready(csr_ready), .ld_resp(ld_resp), .irq(irq),
        .eentry(EENTRY), .tlbrentry(TLBRENTRY), .allowin(allowin),
        .wport0(wport0), .wport1(wport1), .wport2(wport2), .exc(exc),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic wb_pkg::wb_slot_t alu_slot(logic [31:0] pc, logic [4:0] rd,
                                                  logic [31:0] a, logic link);
        wb_pkg::wb_slot_t s;
        s = '0;
        s.valid = 1'b1;
        s.pc = pc;
        // jirl opcode sits in inst[30:26]
        s.inst = link ? 32'h4c00_0000 : 32'h0010_0000;
        s.uop.kind = wb_pkg::WB_ALU;
        s.rd = rd;
        s.op_a = a;
        return s;
    endfunction

    function automatic wb_pkg::wb_slot_t div_slot(logic [31:0] pc, logic [4:0] rd,
                                                  logic [31:0] a, logic [31:0] b, logic rem);
        wb_pkg::wb_slot_t s;
        s = alu_slot(pc, rd, a, 1'b0);
        s.uop.kind = wb_pkg::WB_DIV;
        s.uop.cond.div.rem_sel = rem;
        s.op_b = b;
        return s;
    endfunction

    function automatic wb_pkg::wb_slot_t csr_slot(logic [31:0] pc, logic [4:0] rd);
        wb_pkg::wb_slot_t s;
        s = alu_slot(pc, rd, 32'h0, 1'b0);
        s.uop.kind = wb_pkg::WB_CSR;
        return s;
    endfunction

    function automatic wb_pkg::wb_slot_t exc_slot(logic [31:0] pc, wb_pkg::wb_ecode_e ec,
                                                  logic [31:0] badv);
        wb_pkg::wb_slot_t s;
        s = alu_slot(pc, 5'd3, 32'h5555_0000, 1'b0);
        s.uop.exc.flag = 1'b1;
        s.uop.exc.ecode = ec;
        s.uop.exc.badv = badv;
        return s;
    endfunction

    function automatic entry_t mk_entry(wb_pkg::wb_slot_t s0, wb_pkg::wb_slot_t s1,
                                        logic [7:0] delay, logic [31:0] cdata,
                                        wb_pkg::ld_resp_t ld, logic irq_in);
        entry_t e;
        e.s0 = s0;
        e.s1 = s1;
        e.csr_delay = delay;
        e.csr_data = cdata;
        e.ld = ld;
        e.irq = irq_in;
        return e;
    endfunction

    // expected write of a slot that completes one cycle after accept
    function automatic wb_pkg::wb_port_t slot_port(wb_pkg::wb_slot_t s);
        wb_pkg::wb_port_t p;
        p = '0;
        if (s.valid && s.uop.kind == wb_pkg::WB_ALU && !s.uop.exc.flag) begin
            p.we = 1'b1;
            p.rd = s.rd;
            p.data = (s.inst[30:26] == 5'b10011) ? s.op_a + 32'd4 : s.op_a;
        end
        return p;
    endfunction

    function automatic logic [31:0] div_result(wb_pkg::wb_slot_t s);
        if (s.op_b == 0) begin
            return s.uop.cond.div.rem_sel ? s.op_a : 32'hffff_ffff;
        end
        return s.uop.cond.div.rem_sel ? s.op_a % s.op_b : s.op_a / s.op_b;
    endfunction

    function automatic wb_pkg::exc_csr_t exc_model(wb_pkg::wb_slot_t s, logic from_irq,
                                                   logic [31:0] era);
        wb_pkg::exc_csr_t x;
        wb_pkg::wb_ecode_e ec;
        ec = s.uop.exc.ecode;
        x = '0;
        x.flush = 1'b1;
        x.wen_era = 1'b1;
        x.era = era;
        x.badv = s.uop.exc.badv;
        x.vppn = s.uop.exc.badv[`WB_VPPN_W-1:0];
        if (!from_irq) begin
            x.ecode = ec;
            x.wen_badv = ec inside {wb_pkg::ECODE_PIL, wb_pkg::ECODE_PIS, wb_pkg::ECODE_PIF,
                                    wb_pkg::ECODE_PME, wb_pkg::ECODE_PPI, wb_pkg::ECODE_ADEF,
                                    wb_pkg::ECODE_ALE, wb_pkg::ECODE_TLBR};
            x.wen_vppn = x.wen_badv && ec != wb_pkg::ECODE_ADEF && ec != wb_pkg::ECODE_ALE;
            x.tlb_refill = (ec == wb_pkg::ECODE_TLBR);
        end
        return x;
    endfunction

    task automatic check_port(string name, wb_pkg::wb_port_t got, wb_pkg::wb_port_t exp);
        if (got.we !== exp.we || (exp.we && (got.rd !== exp.rd || got.data !== exp.data))) begin
            $display("mismatch t=%0t %s got we=%0b rd=%0d data=%h exp we=%0b rd=%0d data=%h",
                     $time, name, got.we, got.rd, got.data, exp.we, exp.rd, exp.data);
            mismatches++;
        end
    endtask

    task automatic check_exc(wb_pkg::exc_csr_t got, wb_pkg::exc_csr_t exp);
        logic bad;
        bad = exp.flush ? (got !== exp)
                        : (got.flush !== 1'b0 || got.wen_era !== 1'b0 ||
                           got.wen_badv !== 1'b0 || got.wen_vppn !== 1'b0 ||
                           got.tlb_refill !== 1'b0);
        if (bad) begin
            $display("mismatch t=%0t exc got %h exp %h", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_redirect(logic exp_v, logic [31:0] exp_pc);
        if (redirect !== exp_v || (exp_v && redirect_pc !== exp_pc)) begin
            $display("mismatch t=%0t redirect got %0b/%h exp %0b/%h",
                     $time, redirect, redirect_pc, exp_v, exp_pc);
            mismatches++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch t=%0t %s got %0b exp %0b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic drive_idle();
        slot0 = '0;
        slot1 = '0;
        irq = 1'b0;
        ld_resp = '0;
        csr_ready = 1'b0;
    endtask

    task automatic check_quiet_ports();
        check_port("wport0", wport0, '0);
        check_port("wport1", wport1, '0);
        check_port("wport2", wport2, '0);
    endtask

    task automatic run_plain(entry_t e);
        slot0 = e.s0;
        slot1 = e.s1;
        ld_resp = e.ld;
        #1 check_bit("allowin", allowin, 1'b1);
        if (e.s0.valid) last_pc = e.s0.pc;
        @(negedge clk);
        check_port("wport0", wport0, slot_port(e.s0));
        check_port("wport1", wport1, slot_port(e.s1));
        check_port("wport2", wport2,
                   wb_pkg::wb_port_t'{we: e.ld.valid, rd: e.ld.rd, data: e.ld.data});
        check_exc(exc, '0);
        check_redirect(1'b0, '0);
        drive_idle();
    endtask

    task automatic run_div(entry_t e);
        wb_pkg::wb_port_t exp [3];
        int idx;
        idx = (e.s1.valid && e.s1.uop.kind == wb_pkg::WB_DIV) ? 1 : 0;
        slot0 = e.s0;
        slot1 = e.s1;
        #1 check_bit("allowin", allowin, 1'b1);
        if (e.s0.valid) last_pc = e.s0.pc;
        for (int k = 0; k <= `WB_DIV_CYCLES + 1; k++) begin
            @(negedge clk);
            exp[0] = (k == 0) ? slot_port(e.s0) : '0;
            exp[1] = (k == 0) ? slot_port(e.s1) : '0;
            exp[2] = (k == 3) ? wb_pkg::wb_port_t'{we: e.ld.valid, rd: e.ld.rd,
                                                   data: e.ld.data} : '0;
            if (k == `WB_DIV_CYCLES + 1) begin
                exp[idx] = '{we: 1'b1, rd: (idx == 1) ? e.s1.rd : e.s0.rd,
                             data: div_result((idx == 1) ? e.s1 : e.s0)};
            end
            check_bit("allowin", allowin, k >= `WB_DIV_CYCLES);
            check_port("wport0", wport0, exp[0]);
            check_port("wport1", wport1, exp[1]);
            check_port("wport2", wport2, exp[2]);
            if (k == 0) drive_idle();
            // load return while the divider holds the slots
            if (k == 2) ld_resp = e.ld;
            if (k == 3) ld_resp = '0;
        end
    endtask

    task automatic run_csr(entry_t e);
        slot0 = e.s0;
        slot1 = e.s1;
        csr_rdata = e.csr_data;
        csr_ready = (e.csr_delay == 0);
        for (int k = 0; k < e.csr_delay; k++) begin
            #1 check_bit("allowin", allowin, 1'b0);
            @(negedge clk);
            check_quiet_ports();
            check_redirect(1'b0, '0);
        end
        csr_ready = 1'b1;
        #1 check_bit("allowin", allowin, 1'b1);
        last_pc = e.s0.pc;
        @(negedge clk);
        check_port("wport0", wport0,
                   wb_pkg::wb_port_t'{we: 1'b1, rd: e.s0.rd, data: e.csr_data});
        check_port("wport1", wport1, slot_port(e.s1));
        check_exc(exc, '0);
        check_redirect(1'b1, e.s0.pc + 32'd4);
        drive_idle();
    endtask

    task automatic run_exc(entry_t e);
        slot0 = e.s0;
        slot1 = e.s1;
        #1 check_bit("allowin", allowin, 1'b1);
        last_pc = e.s0.pc;
        @(negedge clk);
        check_quiet_ports();
        check_exc(exc, exc_model(e.s0, 1'b0, e.s0.pc));
        check_redirect(1'b1, (e.s0.uop.exc.ecode == wb_pkg::ECODE_TLBR) ? TLBRENTRY : EENTRY);
        drive_idle();
    endtask

    task automatic run_irq();
        irq = 1'b1;
        @(negedge clk);
        check_quiet_ports();
        check_exc(exc, exc_model('0, 1'b1, last_pc));
        check_redirect(1'b1, EENTRY);
        drive_idle();
    endtask

    task automatic build_table();
        wb_pkg::wb_ecode_e codes [10];
        wb_pkg::ld_resp_t ld;
        codes = '{wb_pkg::ECODE_PIL, wb_pkg::ECODE_PIS, wb_pkg::ECODE_PIF, wb_pkg::ECODE_PME,
                  wb_pkg::ECODE_PPI, wb_pkg::ECODE_ADEF, wb_pkg::ECODE_ALE,
                  wb_pkg::ECODE_TLBR, wb_pkg::ECODE_SYS, wb_pkg::ECODE_BRK};
        ld = '{valid: 1'b1, rd: 5'd9, data: $urandom};
        table_q[0] = mk_entry(alu_slot(32'h1000, 5'd1, 32'h1111_2222, 1'b0),
                              alu_slot(32'h1004, 5'd2, 32'h3333_4444, 1'b0), 0, 0, '0, 0);
        table_q[1] = mk_entry(alu_slot(32'h1008, 5'd3, 32'h0000_1008, 1'b0),
                              alu_slot(32'h100c, 5'd1, 32'h0000_100c, 1'b1), 0, 0, '0, 0);
        table_q[2] = mk_entry(alu_slot(32'h1010, 5'd1, 32'hffff_fffc, 1'b1),
                              alu_slot(32'h1014, 5'd4, 32'h0bad_f00d, 1'b0), 0, 0, '0, 0);
        table_q[3] = mk_entry(div_slot(32'h1018, 5'd5, $urandom, $urandom % 1000 + 1, 1'b0),
                              alu_slot(32'h101c, 5'd6, 32'h6, 1'b0), 0, 0, '0, 0);
        table_q[4] = mk_entry(alu_slot(32'h1020, 5'd7, 32'h7, 1'b0),
                              div_slot(32'h1024, 5'd8, $urandom, $urandom, 1'b1), 0, 0, '0, 0);
        table_q[5] = mk_entry(div_slot(32'h1028, 5'd10, $urandom, 32'h0, 1'b1),
                              '0, 0, 0, '0, 0);
        table_q[6] = mk_entry(alu_slot(32'h102c, 5'd11, 32'h11, 1'b0),
                              div_slot(32'h1030, 5'd12, $urandom, 32'h0, 1'b0), 0, 0, '0, 0);
        table_q[7] = mk_entry(div_slot(32'h1034, 5'd13, $urandom, $urandom % 97 + 1, 1'b0),
                              '0, 0, 0, ld, 0);
        table_q[8] = mk_entry(csr_slot(32'h1038, 5'd14), '0, 0, 32'hc5c5_0001, '0, 0);
        table_q[9] = mk_entry(csr_slot(32'h103c, 5'd15),
                              alu_slot(32'h1040, 5'd16, 32'h16, 1'b0), 3, 32'hc5c5_0002, '0, 0);
        ld = '{valid: 1'b1, rd: 5'd17, data: $urandom};
        table_q[10] = mk_entry('0, '0, 0, 0, ld, 0);
        ld = '{valid: 1'b1, rd: 5'd18, data: $urandom};
        table_q[11] = mk_entry(alu_slot(32'h1044, 5'd19, 32'h19, 1'b0),
                               alu_slot(32'h1048, 5'd20, 32'h20, 1'b0), 0, 0, ld, 0);
        for (int i = 0; i < 10; i++) begin
            table_q[12 + i] = mk_entry(exc_slot(32'h2000 + 32'(i * 8), codes[i], $urandom),
                                       alu_slot(32'h2004 + 32'(i * 8), 5'd21, 32'h21, 1'b0),
                                       0, 0, '0, 0);
        end
        table_q[22] = mk_entry('0, '0, 0, 0, '0, 1);
        table_q[23] = mk_entry(alu_slot(32'h3000, 5'd22, 32'hdead_beef, 1'b0),
                               alu_slot(32'h3004, 5'd23, 32'hcafe_f00d, 1'b1), 0, 0, '0, 0);
    endtask

    initial begin
        entry_t e;
        aresetn = 1'b0;
        csr_rdata = '0;
        drive_idle();
        void'($urandom(32'h058e_20e8));
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;
        @(negedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            e = table_q[i];
            if (e.irq) begin
                run_irq();
            end else if (e.s0.valid && e.s0.uop.exc.flag) begin
                run_exc(e);
            end else if (e.s0.valid && e.s0.uop.kind == wb_pkg::WB_CSR) begin
                run_csr(e);
            end else if ((e.s0.valid && e.s0.uop.kind == wb_pkg::WB_DIV) ||
                         (e.s1.valid && e.s1.uop.kind == wb_pkg::WB_DIV)) begin
                run_div(e);
            end else begin
                run_plain(e);
            end
            // one idle cycle between entries
            @(negedge clk);
        end
        $display("errors: %0d mismatches over %0d entries", mismatches, N_ENTRIES);
        if (mismatches == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wb_top.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/uop_decode.sv
verilog/div_unit.sv
verilog/wb_stage.sv
verilog/exc_commit.sv
verilog/wb_top.sv
verif/wb_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module wb_tb -f wb_top.f -o wb_sim &&
./obj_dir/wb_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
